// File: all.f
+incdir+verilog
verilog/vpu_fp_pkg.sv
verilog/vpu_op_pkg.sv
verilog/vpu_src_port.sv
verilog/vpu_fp_cmp.sv
verilog/vpu_fp_max.sv
verilog/vpu_dst_port.sv
verilog/vpu_fp_top.sv
verif/vpu_clk_gen.sv
verif/vpu_fp_monitor.sv
verif/vpu_fp_checker.sv
verif/vpu_fp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module vpu_fp_tb -o vpu_fp_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/vpu_fp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: verif/vpu_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module vpu_clk_gen #(
    parameter real HALF_PERIOD = 5.0,
    parameter int  RST_CYCLES  = 3
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                          // Seen high from the next edge on.
    end

endmodule

`default_nettype wire

// File: verif/vpu_fp_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_fp_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          in_valid,
    input logic                          in_ready,
    input logic                          out_valid,
    input logic                          out_ready,
    input logic [`VPU_OPERAND_WIDTH-1:0] result,
    input logic                          nan_flag
);
    int assert_errors = 0;

    no_xfer_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(in_valid && in_ready) && !(out_valid && out_ready))
        else begin
            assert_errors++;
            $error("handshake transfer while in reset");
        end

    // Idle and open for requests on the first cycle out of reset.
    after_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> in_ready && !out_valid)
        else begin
            assert_errors++;
            $error("in_ready low or out_valid high right after reset");
        end

    // Output word holds under back-pressure.
    out_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(result) && $stable(nan_flag))
        else begin
            assert_errors++;
            $error("output changed while stalled");
        end

endmodule

bind vpu_fp_top vpu_fp_checker checker_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result),
    .nan_flag  (nan_flag)
);

`default_nettype wire

// File: verif/vpu_fp_monitor.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_fp_monitor (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic                          in_ready,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_0,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_1,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_2,
    input  logic                          use_op_2,
    input  vpu_op_pkg::vpu_fp_op_e        op,
    input  logic                          out_valid,
    input  logic                          out_ready,
    input  logic [`VPU_OPERAND_WIDTH-1:0] result,
    input  logic                          nan_flag,
    output int                            value_errors,
    output int                            timing_errors,
    output int                            results_seen
);
    logic [`VPU_OPERAND_WIDTH:0] exp_q [$];     // {nan, result}.
    int unsigned                 acc_q [$];
    int unsigned                 cyc;
    logic                        out_valid_q;
    logic                        in_reset_q;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic is_nan(input logic [31:0] w);
        return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
    endfunction

    // Maps a float onto an unsigned scale that follows sign and magnitude.
    function automatic logic [31:0] order_key(input logic [31:0] w);
        if (w[31]) begin
            return ~w;
        end
        return w | 32'h8000_0000;
    endfunction

    function automatic logic [31:0] pick_pair(input logic [31:0] a, input logic [31:0] b,
                                              input vpu_op_pkg::vpu_fp_op_e opc);
        if (is_nan(a) && is_nan(b)) begin
            return vpu_fp_pkg::FP32_QNAN;
        end
        if (is_nan(a)) begin
            return b;
        end
        if (is_nan(b)) begin
            return a;
        end
        if (opc == vpu_op_pkg::FP_MAX) begin
            return (order_key(b) > order_key(a)) ? b : a;   // Ties keep a.
        end
        return (order_key(b) < order_key(a)) ? b : a;
    endfunction

    function automatic logic [32:0] model_result(input logic [31:0] a, input logic [31:0] b,
                                                 input logic [31:0] c, input logic three,
                                                 input vpu_op_pkg::vpu_fp_op_e opc);
        logic [31:0] w;
        logic        flag;
        w    = pick_pair(a, b, opc);
        flag = is_nan(a) || is_nan(b);
        if (three) begin
            w    = pick_pair(w, c, opc);
            flag = flag || is_nan(c);
        end
        return {flag, w};
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [32:0] expd;
        logic        exp_ready;
        if (!rst_n) begin
            exp_q.delete();
            acc_q.delete();
            value_errors  = 0;
            timing_errors = 0;
            results_seen  = 0;
            out_valid_q   = 1'b0;
            in_reset_q    = 1'b1;
        end else begin
            if (in_reset_q && out_valid) begin
                $display("Fail at %0t: out_valid expected 0 actual %b", $time, out_valid);
                timing_errors++;
            end
            exp_ready = exp_q.size() < `VPU_DST_DEPTH;          // Credit rule.
            if (in_ready !== exp_ready) begin
                $display("Fail at %0t: in_ready expected %b actual %b",
                         $time, exp_ready, in_ready);
                timing_errors++;
            end
            if (out_valid && !out_valid_q && acc_q.size() > 0) begin
                if (cyc - acc_q[0] != 4) begin
                    $display("Fail at %0t: out_valid latency expected 4 actual %0d",
                             $time, cyc - acc_q[0]);
                    timing_errors++;
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: a result came out with no request pending", $time);
                    value_errors++;
                end else begin
                    expd = exp_q.pop_front();
                    void'(acc_q.pop_front());
                    if (result !== expd[31:0]) begin
                        $display("Fail at %0t: result expected %08h actual %08h",
                                 $time, expd[31:0], result);
                        value_errors++;
                    end
                    if (nan_flag !== expd[32]) begin
                        $display("Fail at %0t: nan_flag expected %b actual %b",
                                 $time, expd[32], nan_flag);
                        value_errors++;
                    end
                    results_seen++;
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(model_result(op_0, op_1, op_2, use_op_2, op));
                acc_q.push_back(cyc);
            end
            out_valid_q = out_valid;
            in_reset_q  = 1'b0;
        end
        cyc++;
    end

endmodule

`default_nettype wire

// File: verif/vpu_fp_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_fp_tb;
    localparam int          NUM_REQ        = 400;
    localparam int          TIMEOUT_CYCLES = NUM_REQ * 20 + 500;
    localparam logic [31:0] SEED           = 32'hd1d7b6e1;

    logic                          clk;
    logic                          rst_n;
    logic                          in_valid;
    logic                          in_ready;
    logic [`VPU_OPERAND_WIDTH-1:0] op_0;
    logic [`VPU_OPERAND_WIDTH-1:0] op_1;
    logic [`VPU_OPERAND_WIDTH-1:0] op_2;
    logic                          use_op_2;
    vpu_op_pkg::vpu_fp_op_e        op;
    logic                          out_valid;
    logic                          out_ready;
    logic [`VPU_OPERAND_WIDTH-1:0] result;
    logic                          nan_flag;
    int                            value_errors;
    int                            timing_errors;
    int                            results_seen;

    vpu_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

    vpu_fp_top vpu_fp_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op_0      (op_0),
        .op_1      (op_1),
        .op_2      (op_2),
        .use_op_2  (use_op_2),
        .op        (op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .nan_flag  (nan_flag)
    );

    vpu_fp_monitor monitor (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .op_0          (op_0),
        .op_1          (op_1),
        .op_2          (op_2),
        .use_op_2      (use_op_2),
        .op            (op),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .result        (result),
        .nan_flag      (nan_flag),
        .value_errors  (value_errors),
        .timing_errors (timing_errors),
        .results_seen  (results_seen)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Zeros, infinities, NaNs and a small pool for ties.
    function automatic logic [31:0] rand_operand();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 9))
            0: w = 32'h0000_0000;
            1: w = 32'h8000_0000;
            2: w = 32'h7f80_0000;
            3: w = 32'hff80_0000;
            4: begin
                w[30:23] = 8'hff;
                if (w[22:0] == 23'd0) w[0] = 1'b1;
            end
            5, 6: begin
                case ($urandom_range(0, 3))
                    0: w = 32'h3f80_0000;
                    1: w = 32'hbf80_0000;
                    2: w = 32'h4000_0000;
                    default: w = 32'hc000_0000;
                endcase
            end
            default: w = $urandom;
        endcase
        return w;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer.
    task automatic send_request(input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] c, input logic three,
                                input vpu_op_pkg::vpu_fp_op_e opc);
        op_0     = a;
        op_1     = b;
        op_2     = c;
        use_op_2 = three;
        op       = opc;
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            c;
        logic                   three;
        vpu_op_pkg::vpu_fp_op_e opc;
        int                     assert_errors;
        void'($urandom(SEED));
        in_valid = 1'b0;
        op_0     = '0;
        op_1     = '0;
        op_2     = '0;
        use_op_2 = 1'b0;
        op       = vpu_op_pkg::FP_MAX;
        wait (rst_n === 1'b1);
        @(negedge clk);
        for (int i = 0; i < NUM_REQ; i++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
            a     = rand_operand();
            b     = ($urandom_range(0, 4) == 0) ? a : rand_operand();   // Equal pairs.
            c     = ($urandom_range(0, 5) == 0) ? a : rand_operand();
            three = ($urandom_range(0, 1) == 1);
            opc   = ($urandom_range(0, 1) == 1) ? vpu_op_pkg::FP_MIN : vpu_op_pkg::FP_MAX;
            send_request(a, b, c, three, opc);
        end
        wait (results_seen == NUM_REQ);
        repeat (4) @(posedge clk);
        assert_errors = vpu_fp_top_inst.checker_inst.assert_errors;
        $display("Checked %0d results: %0d value, %0d timing, %0d assertion errors",
                 results_seen, value_errors, timing_errors, assert_errors);
        if (value_errors == 0 && timing_errors == 0 && assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Stretches of stall, drain and random back-pressure.
    initial begin : drain
        int unsigned len;
        int unsigned mode;
        out_ready = 1'b0;
        @(negedge clk);
        out_ready = 1'b1;                       // Ready through reset.
        wait (rst_n === 1'b1);
        forever begin
            len  = $urandom_range(5, 40);
            mode = $urandom_range(0, 2);
            repeat (len) begin
                @(negedge clk);
                case (mode)
                    0:       out_ready = 1'b0;
                    1:       out_ready = 1'b1;
                    default: out_ready = ($urandom_range(0, 1) == 1);
                endcase
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles: only %0d of %0d results arrived",
                 TIMEOUT_CYCLES, results_seen, NUM_REQ);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/vpu_dst_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_dst_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          accept,
    input  logic                          m_valid,
    input  logic [`VPU_OPERAND_WIDTH-1:0] m_result,
    input  logic                          m_nan,
    input  logic                          out_ready,
    output logic                          credit_ok,
    output logic                          out_valid,
    output logic [`VPU_OPERAND_WIDTH-1:0] result,
    output logic                          nan_flag
);
    localparam int DEPTH = `VPU_DST_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`VPU_OPERAND_WIDTH:0] mem [DEPTH];   // {nan, result}.
    logic [PTR_W:0]              wr_ptr;
    logic [PTR_W:0]              rd_ptr;
    logic [PTR_W:0]              credit;
    logic                        pop;

    ////////////////////////////////////////////////////////////
    // FIFO
    ////////////////////////////////////////////////////////////

    assign out_valid          = wr_ptr != rd_ptr;
    assign pop                = out_valid && out_ready;
    assign {nan_flag, result} = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (m_valid) begin
            mem[wr_ptr[PTR_W-1:0]] <= {m_nan, m_result};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (m_valid) wr_ptr <= wr_ptr + 1'b1;   // Never full, credits hold it.
            if (pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Credits
    ////////////////////////////////////////////////////////////

    // Counts requests accepted but not yet read out.
    assign credit_ok = credit < (PTR_W + 1)'(DEPTH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit <= '0;
        end else begin
            case ({accept, pop})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/vpu_fp_cmp.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_fp_cmp (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          a_valid,
    input  logic [`VPU_OPERAND_WIDTH-1:0] a,
    input  logic [`VPU_OPERAND_WIDTH-1:0] b,
    input  vpu_op_pkg::vpu_fp_op_e        op,
    input  logic [`VPU_OPERAND_WIDTH:0]   carry,
    input  logic                          a_nan_in,
    output logic                          r_valid,
    output logic [`VPU_OPERAND_WIDTH-1:0] r,
    output logic                          r_nan,
    output logic [`VPU_OPERAND_WIDTH:0]   r_carry
);
    vpu_fp_pkg::fp32_word_u        a_u;
    vpu_fp_pkg::fp32_word_u        b_u;
    logic                          a_is_nan;
    logic                          b_is_nan;
    logic [`VPU_OPERAND_WIDTH-1:0] win;

    // Sign first, then magnitude; -0 sits below +0.
    function automatic logic greater(vpu_fp_pkg::fp32_word_u x, vpu_fp_pkg::fp32_word_u y);
        if (x.fields.sign != y.fields.sign) begin
            return !x.fields.sign;
        end
        if (!x.fields.sign) begin
            return x.raw[30:0] > y.raw[30:0];
        end
        return x.raw[30:0] < y.raw[30:0];       // Both negative.
    endfunction

    ////////////////////////////////////////////////////////////
    // Winner select
    ////////////////////////////////////////////////////////////

    assign a_u      = a;
    assign b_u      = b;
    assign a_is_nan = (a_u.fields.exponent == 8'hff) && (a_u.fields.mantissa != '0);
    assign b_is_nan = (b_u.fields.exponent == 8'hff) && (b_u.fields.mantissa != '0);

    always_comb begin
        if (a_is_nan && b_is_nan) begin
            win = vpu_fp_pkg::FP32_QNAN;
        end else if (a_is_nan) begin
            win = b;
        end else if (b_is_nan) begin
            win = a;
        end else if (op == vpu_op_pkg::FP_MAX) begin
            win = greater(b_u, a_u) ? b : a;    // Ties keep a.
        end else begin
            win = greater(a_u, b_u) ? b : a;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= a_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (a_valid) begin
            r       <= win;
            r_nan   <= a_nan_in || a_is_nan || b_is_nan;
            r_carry <= carry;
        end
    end

endmodule

`default_nettype wire

// File: verilog/vpu_fp_max.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_fp_max (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          s_valid,
    input  logic [`VPU_OPERAND_WIDTH-1:0] s_op_0,
    input  logic [`VPU_OPERAND_WIDTH-1:0] s_op_1,
    input  logic [`VPU_OPERAND_WIDTH-1:0] s_op_2,
    input  logic                          s_use_op_2,
    input  vpu_op_pkg::vpu_fp_op_e        s_op,
    output logic                          m_valid,
    output logic [`VPU_OPERAND_WIDTH-1:0] m_result,
    output logic                          m_nan
);
    vpu_op_pkg::vpu_req_tag_t      s_tag;
    vpu_op_pkg::vpu_req_tag_t      x_tag;
    logic                          x_valid;
    logic [`VPU_OPERAND_WIDTH-1:0] x_r;
    logic                          x_nan;
    vpu_op_pkg::vpu_fp_op_e        x_op;
    logic [`VPU_OPERAND_WIDTH-1:0] b_1;

    ////////////////////////////////////////////////////////////
    // Stage 0: op_0 against op_1
    ////////////////////////////////////////////////////////////

    assign s_tag = '{use_op_2: s_use_op_2, op_2: s_op_2};

    vpu_fp_cmp stage_0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_valid  (s_valid),
        .a        (s_op_0),
        .b        (s_op_1),
        .op       (s_op),
        .carry    (s_tag),
        .a_nan_in (1'b0),
        .r_valid  (x_valid),
        .r        (x_r),
        .r_nan    (x_nan),
        .r_carry  (x_tag)
    );

    always_ff @(posedge clk) begin
        if (s_valid) begin
            x_op <= s_op;                       // Opcode for stage 1.
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 1: winner against op_2
    ////////////////////////////////////////////////////////////

    // Two-operand requests compare the winner with itself,
    // so it passes through with its flag in the same cycle.
    assign b_1 = x_tag.use_op_2 ? x_tag.op_2 : x_r;

    vpu_fp_cmp stage_1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_valid  (x_valid),
        .a        (x_r),
        .b        (b_1),
        .op       (x_op),
        .carry    (x_tag),
        .a_nan_in (x_nan),
        .r_valid  (m_valid),
        .r        (m_result),
        .r_nan    (m_nan),
        .r_carry  ()
    );

endmodule

`default_nettype wire

// File: verilog/vpu_fp_pkg.sv
`default_nettype none

package vpu_fp_pkg;

    ////////////////////////////////////////////////////////////
    // Single-precision word views.
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] fp32_raw_t;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // Same word, seen as raw bits or as IEEE fields.
    typedef union packed {
        fp32_raw_t    raw;
        fp32_fields_t fields;
    } fp32_word_u;

    localparam fp32_raw_t FP32_QNAN = 32'h7fc0_0000;  // Canonical quiet NaN.

endpackage

`default_nettype wire

// File: verilog/vpu_fp_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_fp_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_0,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_1,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_2,
    input  logic                          use_op_2,
    input  vpu_op_pkg::vpu_fp_op_e        op,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [`VPU_OPERAND_WIDTH-1:0] result,
    output logic                          nan_flag
);
    logic                          accept;
    logic                          credit_ok;
    logic                          s_valid;
    logic [`VPU_OPERAND_WIDTH-1:0] s_op_0;
    logic [`VPU_OPERAND_WIDTH-1:0] s_op_1;
    logic [`VPU_OPERAND_WIDTH-1:0] s_op_2;
    logic                          s_use_op_2;
    vpu_op_pkg::vpu_fp_op_e        s_op;
    logic                          m_valid;
    logic [`VPU_OPERAND_WIDTH-1:0] m_result;
    logic                          m_nan;

    vpu_src_port src_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .op_0       (op_0),
        .op_1       (op_1),
        .op_2       (op_2),
        .use_op_2   (use_op_2),
        .op         (op),
        .credit_ok  (credit_ok),
        .in_ready   (in_ready),
        .accept     (accept),
        .s_valid    (s_valid),
        .s_op_0     (s_op_0),
        .s_op_1     (s_op_1),
        .s_op_2     (s_op_2),
        .s_use_op_2 (s_use_op_2),
        .s_op       (s_op)
    );

    vpu_fp_max fp_max (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_op_0     (s_op_0),
        .s_op_1     (s_op_1),
        .s_op_2     (s_op_2),
        .s_use_op_2 (s_use_op_2),
        .s_op       (s_op),
        .m_valid    (m_valid),
        .m_result   (m_result),
        .m_nan      (m_nan)
    );

    vpu_dst_port dst_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .m_valid    (m_valid),
        .m_result   (m_result),
        .m_nan      (m_nan),
        .out_ready  (out_ready),
        .credit_ok  (credit_ok),
        .out_valid  (out_valid),
        .result     (result),
        .nan_flag   (nan_flag)
    );

endmodule

`default_nettype wire

// File: verilog/vpu_op_pkg.sv
`default_nettype none

`include "vpu_params.svh"

package vpu_op_pkg;

    typedef enum logic {
        FP_MAX = 1'b0,
        FP_MIN = 1'b1
    } vpu_fp_op_e;

    // Third operand riding along stage 0.
    typedef struct packed {
        logic                          use_op_2;
        logic [`VPU_OPERAND_WIDTH-1:0] op_2;
    } vpu_req_tag_t;

endpackage

`default_nettype wire

// File: verilog/vpu_params.svh
`ifndef VPU_PARAMS_SVH
`define VPU_PARAMS_SVH

////////////////////////////////////////////////////////////
// Lane geometry.
////////////////////////////////////////////////////////////

`define VPU_OPERAND_WIDTH 32
`define VPU_SRC_OPERAND_CNT 3

// Power of two, sets the credit limit too.
`define VPU_DST_DEPTH 4

`endif

// File: verilog/vpu_src_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "vpu_params.svh"

module vpu_src_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_0,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_1,
    input  logic [`VPU_OPERAND_WIDTH-1:0] op_2,
    input  logic                          use_op_2,
    input  vpu_op_pkg::vpu_fp_op_e        op,
    input  logic                          credit_ok,
    output logic                          in_ready,
    output logic                          accept,
    output logic                          s_valid,
    output logic [`VPU_OPERAND_WIDTH-1:0] s_op_0,
    output logic [`VPU_OPERAND_WIDTH-1:0] s_op_1,
    output logic [`VPU_OPERAND_WIDTH-1:0] s_op_2,
    output logic                          s_use_op_2,
    output vpu_op_pkg::vpu_fp_op_e        s_op
);
    logic [`VPU_OPERAND_WIDTH-1:0] opnd_q [`VPU_SRC_OPERAND_CNT];
    logic                          use_op_2_q;
    vpu_op_pkg::vpu_fp_op_e        opc_q;

    assign in_ready = credit_ok;                // Room downstream.
    assign accept   = in_valid && credit_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= accept;                  // One pulse per request.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opnd_q[0]  <= op_0;
            opnd_q[1]  <= op_1;
            opnd_q[2]  <= op_2;
            use_op_2_q <= use_op_2;
            opc_q      <= op;
        end
    end

    assign s_op_0     = opnd_q[0];
    assign s_op_1     = opnd_q[1];
    assign s_op_2     = opnd_q[2];
    assign s_use_op_2 = use_op_2_q;
    assign s_op       = opc_q;

endmodule

`default_nettype wire
